//--- rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data word width
`define RV_XLEN 32

// Architectural register file
`define RV_NREGS 32
`define RV_REG_W 5

// Edges from accepted instruction to write-back on the ports
`define RV_WB_LATENCY 2

`endif

//--- rv_pkg.sv
package rv_pkg;

    // Major opcodes handled by the datapath
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register
        OP_IMM = 7'b0010011,  // Register-immediate
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    // I and U immediates both live in the upper 20 bits
    typedef struct packed {
        logic [19:0] upper;
        logic [4:0]  rd;
        opcode_e     opcode;
    } iu_fmt_t;

    typedef union packed {
        r_fmt_t  r_fmt;
        iu_fmt_t iu_fmt;
    } instr_u;

    typedef struct packed {
        funct3_e fn;
        logic    alt;  // SUB or SRA
    } alu_op_t;

endpackage

//--- rv_ifs.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

// Decoded operation, decode to execute
interface dec_op_if;
    import rv_pkg::*;

    logic                 valid;
    alu_op_t              alu_op;
    logic [`RV_REG_W-1:0] rd;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic [`RV_XLEN-1:0]  imm;
    logic                 use_imm;  // Immediate replaces rs2
    logic                 is_lui;

    modport dec (
        output valid, alu_op, rd, rs1, rs2, imm, use_imm, is_lui
    );

    modport exe (
        input valid, alu_op, rd, rs1, rs2, imm, use_imm, is_lui
    );
endinterface

// Combinational register file read, two ports
interface reg_rd_if;
    logic [`RV_REG_W-1:0] rs1_idx;
    logic [`RV_REG_W-1:0] rs2_idx;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;

    modport exe (
        output rs1_idx, rs2_idx,
        input  rs1_data, rs2_data
    );

    modport rf (
        input  rs1_idx, rs2_idx,
        output rs1_data, rs2_data
    );
endinterface

//--- instr_decode.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module instr_decode (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           instr_valid_i,
    input  rv_pkg::instr_u instr_i,
    dec_op_if.dec          dec_o
);
    import rv_pkg::*;

    logic                valid_d;
    logic                use_imm_d;
    logic                is_lui_d;
    alu_op_t             op_d;
    logic [`RV_XLEN-1:0] imm_d;
    logic [`RV_XLEN-1:0] imm_i;

    // I immediate sits in bits 31:20
    assign imm_i = {{(`RV_XLEN-12){instr_i.iu_fmt.upper[19]}}, instr_i.iu_fmt.upper[19:8]};

    always_comb
    begin
        valid_d   = 1'b0;
        use_imm_d = 1'b0;
        is_lui_d  = 1'b0;
        op_d.fn   = instr_i.r_fmt.funct3;
        op_d.alt  = instr_i.r_fmt.funct7[5];
        imm_d     = imm_i;
        case (instr_i.r_fmt.opcode)
            OP:
                valid_d = 1'b1;
            OP_IMM:
            begin
                valid_d   = 1'b1;
                use_imm_d = 1'b1;
                if (op_d.fn == SLL || op_d.fn == SRL_SRA)
                    imm_d = {{(`RV_XLEN-`RV_REG_W){1'b0}}, instr_i.r_fmt.rs2};  // Shamt only
                op_d.alt = (op_d.fn == SRL_SRA) && instr_i.r_fmt.funct7[5];  // ADDI never subtracts
            end
            LUI:
            begin
                valid_d  = 1'b1;
                is_lui_d = 1'b1;
                imm_d    = {instr_i.iu_fmt.upper, {(`RV_XLEN-20){1'b0}}};
            end
            default:
                valid_d = 1'b0;  // Unsupported opcode
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_i)
            dec_o.valid <= 1'b0;
        else
            dec_o.valid <= instr_valid_i && valid_d;
        dec_o.alu_op  <= op_d;
        dec_o.rd      <= instr_i.r_fmt.rd;
        dec_o.rs1     <= instr_i.r_fmt.rs1;
        dec_o.rs2     <= instr_i.r_fmt.rs2;
        dec_o.imm     <= imm_d;
        dec_o.use_imm <= use_imm_d;
        dec_o.is_lui  <= is_lui_d;
    end

endmodule

//--- alu_execute.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module alu_execute (
    input  logic                 clk,
    input  logic                 reset_i,
    dec_op_if.exe                dec_i,
    reg_rd_if.exe                rd_port_o,
    output logic                 wb_valid_o,
    output logic [`RV_REG_W-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]  wb_data_o
);
    import rv_pkg::*;

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic                fwd_rs1;
    logic                fwd_rs2;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_b;
    logic [SHAMT_W-1:0]  shamt;
    logic                lt_s;
    logic                lt_u;
    logic [`RV_XLEN-1:0] alu_res;

    assign rd_port_o.rs1_idx = dec_i.rs1;
    assign rd_port_o.rs2_idx = dec_i.rs2;

    // Previous result is not yet in the register file
    assign fwd_rs1 = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == dec_i.rs1);
    assign fwd_rs2 = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == dec_i.rs2);

    assign op_a    = fwd_rs1 ? wb_data_o : rd_port_o.rs1_data;
    assign rs2_val = fwd_rs2 ? wb_data_o : rd_port_o.rs2_data;
    assign op_b    = dec_i.use_imm ? dec_i.imm : rs2_val;

    assign shamt = op_b[SHAMT_W-1:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb
    begin
        case (dec_i.alu_op.fn)
            ADD_SUB:
                alu_res = dec_i.alu_op.alt ? op_a - op_b : op_a + op_b;
            SLL:
                alu_res = op_a << shamt;
            SLT:
                alu_res = {{(`RV_XLEN-1){1'b0}}, lt_s};
            SLTU:
                alu_res = {{(`RV_XLEN-1){1'b0}}, lt_u};
            XOR:
                alu_res = op_a ^ op_b;
            SRL_SRA:
            begin
                if (dec_i.alu_op.alt)
                    alu_res = $unsigned($signed(op_a) >>> shamt);  // Keep sign
                else
                    alu_res = op_a >> shamt;
            end
            OR:
                alu_res = op_a | op_b;
            default:
                alu_res = op_a & op_b;
        endcase
        if (dec_i.is_lui)
            alu_res = dec_i.imm;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_i)
            wb_valid_o <= 1'b0;
        else
            wb_valid_o <= dec_i.valid;
        wb_rd_o   <= dec_i.rd;
        wb_data_o <= alu_res;
    end

endmodule

//--- result_writeback.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module result_writeback (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 wb_valid_i,
    input  logic [`RV_REG_W-1:0] wb_rd_i,
    input  logic [`RV_XLEN-1:0]  wb_data_i,
    reg_rd_if.rf                 rd_port_i
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    // x0 is never written
    assign wr_en = reset_i && wb_valid_i && (wb_rd_i != '0);

    always_ff @(posedge clk)
    begin
        if (wr_en)
            regs[wb_rd_i] <= wb_data_i;
    end

    always_comb
    begin
        if (rd_port_i.rs1_idx == '0)
            rd_port_i.rs1_data = '0;
        else
            rd_port_i.rs1_data = regs[rd_port_i.rs1_idx];
    end

    always_comb
    begin
        if (rd_port_i.rs2_idx == '0)
            rd_port_i.rs2_data = '0;
        else
            rd_port_i.rs2_data = regs[rd_port_i.rs2_idx];
    end

endmodule

//--- riscv_int_core.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module riscv_int_core (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    output logic                 wb_valid_o,
    output logic [`RV_REG_W-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]  wb_data_o
);

    dec_op_if dec_op ();
    reg_rd_if reg_rd ();

    instr_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_o         (dec_op.dec)
    );

    // Write-back goes to the ports and the register file alike
    alu_execute u_execute (
        .clk        (clk),
        .reset_i    (reset_i),
        .dec_i      (dec_op.exe),
        .rd_port_o  (reg_rd.exe),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    result_writeback u_result (
        .clk        (clk),
        .reset_i    (reset_i),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .rd_port_i  (reg_rd.rf)
    );

endmodule

//--- wb_checker.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module wb_checker (
    input  logic                 clk,
    input  logic                 exp_push_i,
    input  int                   exp_idx_i,
    input  logic [31:0]          exp_instr_i,
    input  logic                 exp_wb_i,
    input  logic [`RV_REG_W-1:0] exp_rd_i,
    input  logic [`RV_XLEN-1:0]  exp_data_i,
    input  logic                 wb_valid_i,
    input  logic [`RV_REG_W-1:0] wb_rd_i,
    input  logic [`RV_XLEN-1:0]  wb_data_i,
    output int                   pass_cnt_o,
    output int                   fail_cnt_o,
    output int                   pending_o
);

    typedef struct {
        int                   due;  // Negedge count where the result shows up
        int                   idx;
        logic [31:0]          instr;
        logic                 wb;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  data;
    } exp_t;

    exp_t exp_q[$];
    int   cycle   = 0;
    int   passes  = 0;
    int   fails   = 0;
    int   pending = 0;

    assign pass_cnt_o = passes;
    assign fail_cnt_o = fails;
    assign pending_o  = pending;

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        exp_t e;
        cycle = cycle + 1;
        if (exp_push_i)
        begin
            e.due   = cycle + `RV_WB_LATENCY;
            e.idx   = exp_idx_i;
            e.instr = exp_instr_i;
            e.wb    = exp_wb_i;
            e.rd    = exp_rd_i;
            e.data  = exp_data_i;
            exp_q.push_back(e);
        end
        if (exp_q.size() != 0 && exp_q[0].due == cycle)
        begin
            e = exp_q.pop_front();
            if (e.wb && wb_valid_i !== 1'b1)
            begin
                $display("test %0d (%h): no write-back arrived for x%0d", e.idx, e.instr, e.rd);
                fails++;
            end
            else if (!e.wb && wb_valid_i !== 1'b0)
            begin
                $display("test %0d (%h): write-back to x%0d although none was expected",
                         e.idx, e.instr, wb_rd_i);
                fails++;
            end
            else if (!e.wb)
            begin
                $display("[PASS] test %0d (%h): no write-back", e.idx, e.instr);
                passes++;
            end
            else if (wb_rd_i !== e.rd || wb_data_i !== e.data)
            begin
                $display("[FAIL] test %0d (%h): expected x%0d = %h, actual x%0d = %h",
                         e.idx, e.instr, e.rd, e.data, wb_rd_i, wb_data_i);
                fails++;
            end
            else
            begin
                $display("[PASS] test %0d (%h): x%0d = %h", e.idx, e.instr, e.rd, e.data);
                passes++;
            end
        end
        else if (wb_valid_i === 1'b1)
        begin
            $display("Write-back to x%0d = %h with no instruction in flight", wb_rd_i, wb_data_i);
            fails++;
        end
        pending = exp_q.size();
    end

endmodule

//--- riscv_asserts.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module riscv_asserts (
    input logic        clk,
    input logic        reset_i,
    input logic        instr_valid_i,
    input logic [31:0] instr_i,
    input logic        wb_valid_o
);
    import rv_pkg::*;

    logic accepted;

    // Only supported opcodes reach write-back
    assign accepted = instr_valid_i && (instr_i[6:0] inside {OP, OP_IMM, LUI});

    wb_after_accept: assert property (@(posedge clk) disable iff (!reset_i)
        accepted |-> ##`RV_WB_LATENCY wb_valid_o)
        else $error("wb_valid_o did not follow an accepted instruction");

    wb_has_source: assert property (@(posedge clk) disable iff (!reset_i)
        wb_valid_o |-> $past(accepted, `RV_WB_LATENCY))
        else $error("wb_valid_o high without an accepted instruction");

    wb_low_in_reset: assert property (@(posedge clk)
        !reset_i |=> !wb_valid_o)
        else $error("wb_valid_o high during reset");

endmodule

bind riscv_int_core riscv_asserts u_asserts (.*);

//--- tb_riscv_int_core.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module tb_riscv_int_core;

    localparam int NUM_PATTERNS = 20;
    localparam int MAX_IDLE     = 2;
    localparam int CYCLE_LIMIT  = 2 * MAX_IDLE * NUM_PATTERNS + `RV_WB_LATENCY + 20;

    logic                 clk;
    logic                 reset_i;
    logic                 instr_valid_i;
    logic [31:0]          instr_i;
    logic                 wb_valid_o;
    logic [`RV_REG_W-1:0] wb_rd_o;
    logic [`RV_XLEN-1:0]  wb_data_o;

    logic                 exp_push;
    int                   exp_idx;
    logic                 exp_wb;
    logic [`RV_XLEN-1:0]  exp_data;
    int                   passes;
    int                   fails;
    int                   pending;

    logic [67:0] patterns [NUM_PATTERNS];  // {flag, instruction, result}
    integer      seed;
    int          cycles;
    int          load_errors;

    riscv_int_core u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    wb_checker u_checker (
        .clk         (clk),
        .exp_push_i  (exp_push),
        .exp_idx_i   (exp_idx),
        .exp_instr_i (instr_i),
        .exp_wb_i    (exp_wb),
        .exp_rd_i    (instr_i[11:7]),  // rd field
        .exp_data_i  (exp_data),
        .wb_valid_i  (wb_valid_o),
        .wb_rd_i     (wb_rd_o),
        .wb_data_i   (wb_data_o),
        .pass_cnt_o  (passes),
        .fail_cnt_o  (fails),
        .pending_o   (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d results outstanding", cycles, pending);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int idle;
        seed          = 32'hf5fe6483;
        reset_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        exp_push      = 1'b0;
        exp_idx       = 0;
        exp_wb        = 1'b0;
        exp_data      = '0;
        load_errors   = 0;
        $readmemh("test_patterns.hex", patterns);
        for (int i = 0; i < NUM_PATTERNS; i++)
        begin
            if ($isunknown(patterns[i]) || patterns[i][63:32] == '0)
                load_errors++;
        end
        if (load_errors != 0)
            $display("Pattern file unreadable, %0d bad entries", load_errors);

        repeat (8) @(posedge clk);
        #1 reset_i = 1'b1;
        repeat (3) @(posedge clk);  // Nothing may appear here

        for (int i = 0; i < NUM_PATTERNS; i++)
        begin
            idle = $random(seed) & 7;
            if (idle > MAX_IDLE)
                idle = 0;
            repeat (idle)
            begin
                #1;
                instr_valid_i = 1'b0;
                exp_push      = 1'b0;
                @(posedge clk);
            end
            #1;
            instr_valid_i = 1'b1;
            instr_i       = patterns[i][63:32];
            exp_push      = 1'b1;
            exp_idx       = i;
            exp_wb        = patterns[i][64];
            exp_data      = patterns[i][31:0];
            @(posedge clk);
        end
        #1;
        instr_valid_i = 1'b0;
        exp_push      = 1'b0;

        while (pending != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);  // Catch stray write-backs

        $display("Summary: %0d of %0d tests passed, %0d failures", passes, NUM_PATTERNS, fails);
        if (fails == 0 && load_errors == 0 && passes == NUM_PATTERNS)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- test_patterns.hex
// Columns: flag_instruction_result. Flag 1 expects a write-back to the rd field
// of the instruction with the given result, flag 0 expects no write-back
1_00500093_00000005
1_ffd00113_fffffffd
1_002081b3_00000002
1_40208233_00000008
1_001122b3_00000001
1_00113333_00000000
1_401153b3_ffffffff
1_001094b3_000000a0
1_0020c533_fffffff8
1_0020e5b3_fffffffd
1_0020f633_00000005
1_40008693_00000405
1_40115713_fffffffe
1_ffe12793_00000001
1_fff0b813_00000001
1_123458b7_12345000
1_7ff8c993_123457ff
1_00708013_0000000c
1_00000933_00000000
0_00108063_00000000

//--- verilog.f
+incdir+.
rv_pkg.sv
rv_ifs.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
riscv_int_core.sv
wb_checker.sv
riscv_asserts.sv
tb_riscv_int_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_int_core
RTL_TOP   ?= riscv_int_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
